/* Bender.yml */
package:
  name: soc_bus

sources:
  # Design sources, package first
  - include_dirs:
      - hw
    files:
      - hw/soc_bus_pkg.sv
      - hw/bus_request_decode.sv
      - hw/local_sram.sv
      - hw/text_vram.sv
      - hw/bus_response_mux.sv
      - hw/soc_bus_top.sv

  # Testbench
  - target: test
    include_dirs:
      - hw
    files:
      - verif/soc_bus_tb.sv

/* hw/bus_request_decode.sv */
`timescale 1ns/10ps
`include "soc_bus_config.svh"

module bus_request_decode (
    input  logic                        clk_rv,
    input  logic                        rst_rv,
    input  logic [`SOC_ADDR_W-1:0]      mem_la_addr,
    input  logic                        mem_valid,
    input  soc_bus_pkg::bus_req_t       mem_req,
    input  logic                        ext_ready,
    output logic                        mem_ready,
    output soc_bus_pkg::region_e        region,
    output logic [`SOC_STRB_W-1:0]      ram_wen,
    output logic                        ctrl_wen,
    output logic                        vram_wen,
    output logic                        ext_valid,
    output soc_bus_pkg::ext_req_t       ext_req
);
    import soc_bus_pkg::*;

    // Control register covers one word
    localparam logic [`SOC_ADDR_W-1:0] CTRL_LIMIT = `SOC_CTRL_BASE + 32'd4;

    region_e la_region;
    logic    pending;
    logic    is_write;
    logic    ready_next;

    // ----------------------------------------------------------
    // Look-ahead decode
    // Address arrives one cycle early, so the compare result is
    // registered and ready when mem_valid rises
    always_comb begin
        if (mem_la_addr < `SOC_RAM_LIMIT) begin
            la_region = REGION_RAM;
        end else if ((mem_la_addr >= `SOC_CTRL_BASE) && (mem_la_addr < CTRL_LIMIT)) begin
            la_region = REGION_CTRL;
        end else if ((mem_la_addr >= `SOC_VRAM_BASE) &&
                     (mem_la_addr < `SOC_VRAM_LIMIT)) begin
            la_region = REGION_VRAM;
        end else if ((mem_la_addr >= `SOC_EXT_BASE) &&
                     (mem_la_addr < `SOC_EXT_LIMIT)) begin
            la_region = REGION_EXT;
        end else begin
            // Hole in the map, reads come back as all ones
            la_region = REGION_NONE;
        end
    end

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region <= REGION_NONE;
        end else begin
            region <= la_region;
        end
    end

    // ----------------------------------------------------------
    // Per-target strobes
    // Access still open until the ready pulse
    assign pending  = mem_valid && !mem_ready;
    assign is_write = |mem_req.wstrb;

    // Byte lanes straight through for the RAM
    assign ram_wen  = (pending && (region == REGION_RAM)) ? mem_req.wstrb : '0;
    assign ctrl_wen = pending && is_write && (region == REGION_CTRL);
    assign vram_wen = pending && is_write && (region == REGION_VRAM);

    // SDRAM side held until its own ready
    assign ext_valid = pending && (region == REGION_EXT);
    assign ext_req   = '{
        addr:  mem_req.addr[`SOC_EXT_ADDR_W-1:0],
        wdata: mem_req.wdata,
        wstrb: mem_req.wstrb
    };

    // ----------------------------------------------------------
    // Ready generation
    // Local targets answer the cycle after mem_valid
    // External target answers the cycle after ext_ready
    always_comb begin
        if (region == REGION_EXT) begin
            ready_next = ext_valid && ext_ready;
        end else begin
            ready_next = pending;
        end
    end

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= ready_next;
        end
    end

    // Exactly one ready pulse per access
    a_ready_single: assert property (
        @(posedge clk_rv) disable iff (!rst_rv)
        mem_ready |=> !mem_ready
    );

    // No SDRAM request for an address outside its window
    // Region was decoded from the look-ahead address
    a_ext_in_window: assert property (
        @(posedge clk_rv) disable iff (!rst_rv)
        ext_valid |-> ((mem_req.addr >= `SOC_EXT_BASE) &&
                       (mem_req.addr < `SOC_EXT_LIMIT))
    );

endmodule

/* hw/bus_response_mux.sv */
`timescale 1ns/10ps
`include "soc_bus_config.svh"

module bus_response_mux (
    input  logic                        clk_rv,
    input  logic                        rst_rv,
    input  soc_bus_pkg::region_e        region,
    input  logic                        ctrl_wen,
    input  logic [`SOC_DATA_W-1:0]      wdata,
    input  logic [`SOC_DELAY_W-1:0]     delay_sel_det,
    input  logic [`SOC_DATA_W-1:0]      ram_rdata,
    input  logic [`SOC_DATA_W-1:0]      ext_rdata,
    output logic [`SOC_DATA_W-1:0]      mem_rdata,
    output logic [`SOC_DELAY_W-1:0]     delay_sel
);
    import soc_bus_pkg::*;

    // SDRAM data held from the ext_ready cycle into the ready cycle
    logic [`SOC_DATA_W-1:0] ext_rdata_q;
    logic [`SOC_DATA_W-1:0] ctrl_rdata;

    // ----------------------------------------------------------
    // Delay-select register
    // Detected tap value loaded while in reset
    // CPU may override it afterwards
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            delay_sel <= delay_sel_det;
        end else if (ctrl_wen) begin
            delay_sel <= wdata[`SOC_DELAY_W-1:0];
        end
    end

    assign ctrl_rdata = {{(`SOC_DATA_W-`SOC_DELAY_W){1'b0}}, delay_sel};

    // Sampled every cycle, only the ext_ready copy is ever used
    always_ff @(posedge clk_rv) begin
        ext_rdata_q <= ext_rdata;
    end

    // ----------------------------------------------------------
    // Read data select
    // Region was registered from the look-ahead address, so it
    // still matches the access when mem_ready is high
    always_comb begin
        case (region)
            REGION_RAM: begin
                mem_rdata = ram_rdata;
            end
            REGION_EXT: begin
                mem_rdata = ext_rdata_q;
            end
            REGION_CTRL: begin
                mem_rdata = ctrl_rdata;
            end
            // Text buffer is write-only from the CPU
            default: begin
                mem_rdata = '1;
            end
        endcase
    end

endmodule

/* hw/local_sram.sv */
`timescale 1ns/10ps
`include "soc_bus_config.svh"

module local_sram (
    input  logic                                clk_rv,
    input  logic [$clog2(`SOC_RAM_WORDS)-1:0]   word_addr,
    input  logic [`SOC_DATA_W-1:0]              wdata,
    input  logic [`SOC_STRB_W-1:0]              wen,
    output logic [`SOC_DATA_W-1:0]              rdata
);

    // Width of one byte lane
    localparam int LANE_W = `SOC_DATA_W / `SOC_STRB_W;

    logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];

    // ----------------------------------------------------------
    // Write port
    // Each strobe bit owns one lane, others keep their contents
    always_ff @(posedge clk_rv) begin
        for (int i = 0; i < `SOC_STRB_W; i++) begin
            if (wen[i]) begin
                mem[word_addr][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
            end
        end
    end

    // ----------------------------------------------------------
    // Read port
    // Registered, data valid one cycle after the address
    // Write in the same cycle returns the old word
    always_ff @(posedge clk_rv) begin
        rdata <= mem[word_addr];
    end

endmodule

/* hw/soc_bus_config.svh */
`ifndef SOC_BUS_CONFIG_SVH
`define SOC_BUS_CONFIG_SVH

// CPU port widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_STRB_W      4

// ----------------------------------------------------------
// Memory map
// Local RAM at the bottom, 4 KiB
`define SOC_RAM_WORDS   1024
`define SOC_RAM_LIMIT   32'h0000_1000
// Single delay-select register, 4 bytes wide
`define SOC_CTRL_BASE   32'h0300_0000
// Text buffer, one character per word
`define SOC_VRAM_BASE   32'h0800_0000
`define SOC_VRAM_LIMIT  32'h0800_4000
// SDRAM window, 32 MiB
`define SOC_EXT_BASE    32'h0C00_0000
`define SOC_EXT_LIMIT   32'h0E00_0000
`define SOC_EXT_ADDR_W  25

// DDR delay tap select
`define SOC_DELAY_W     5

// ----------------------------------------------------------
// Display geometry
`define SOC_TEXT_COLS   80
`define SOC_TEXT_ROWS   25
`define SOC_COL_W       7
`define SOC_ROW_W       5
`define SOC_CHAR_W      7
`define SOC_VRAM_AW     12

`endif

/* hw/soc_bus_pkg.sv */
`include "soc_bus_config.svh"

package soc_bus_pkg;

    // ----------------------------------------------------------
    // Decoded target of a CPU address
    typedef enum logic [2:0] {
        REGION_NONE = 3'd0,
        REGION_RAM  = 3'd1,
        REGION_CTRL = 3'd2,
        REGION_VRAM = 3'd3,
        REGION_EXT  = 3'd4
    } region_e;

    // ----------------------------------------------------------
    // Addressed part of a CPU request
    // Zero wstrb marks a read
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0]     addr;
        logic [`SOC_DATA_W-1:0]     wdata;
        logic [`SOC_STRB_W-1:0]     wstrb;
    } bus_req_t;

    // Request toward the SDRAM window
    // Byte address inside the window only
    typedef struct packed {
        logic [`SOC_EXT_ADDR_W-1:0] addr;
        logic [`SOC_DATA_W-1:0]     wdata;
        logic [`SOC_STRB_W-1:0]     wstrb;
    } ext_req_t;

    // ----------------------------------------------------------
    // Character cell on screen
    typedef struct packed {
        logic [`SOC_COL_W-1:0]      col;
        logic [`SOC_ROW_W-1:0]      row;
    } disp_pos_t;

endpackage

/* hw/soc_bus_top.sv */
`timescale 1ns/10ps
`include "soc_bus_config.svh"

module soc_bus_top (
    input  logic                        clk_rv,
    input  logic                        rst_rv,
    // CPU port
    input  logic [`SOC_ADDR_W-1:0]      mem_la_addr,
    input  logic                        mem_valid,
    input  soc_bus_pkg::bus_req_t       mem_req,
    output logic                        mem_ready,
    output logic [`SOC_DATA_W-1:0]      mem_rdata,
    // SDRAM window
    output logic                        ext_valid,
    output soc_bus_pkg::ext_req_t       ext_req,
    input  logic                        ext_ready,
    input  logic [`SOC_DATA_W-1:0]      ext_rdata,
    // Delay tap
    input  logic [`SOC_DELAY_W-1:0]     delay_sel_det,
    output logic [`SOC_DELAY_W-1:0]     delay_sel,
    // Display scan
    input  soc_bus_pkg::disp_pos_t      disp_pos,
    output logic [`SOC_CHAR_W-1:0]      disp_char
);
    import soc_bus_pkg::*;

    localparam int RAM_AW = $clog2(`SOC_RAM_WORDS);

    region_e                    region;
    logic [`SOC_STRB_W-1:0]     ram_wen;
    logic                       ctrl_wen;
    logic                       vram_wen;
    logic [`SOC_DATA_W-1:0]     ram_rdata;
    logic [RAM_AW-1:0]          ram_word_addr;
    logic [`SOC_VRAM_AW-1:0]    vram_word_addr;

    // ----------------------------------------------------------
    // Word addresses, byte offset dropped
    assign ram_word_addr  = mem_req.addr[RAM_AW+1:2];
    assign vram_word_addr = mem_req.addr[`SOC_VRAM_AW+1:2];

    bus_request_decode u_decode (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_la_addr (mem_la_addr),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req),
        .ext_ready   (ext_ready),
        .mem_ready   (mem_ready),
        .region      (region),
        .ram_wen     (ram_wen),
        .ctrl_wen    (ctrl_wen),
        .vram_wen    (vram_wen),
        .ext_valid   (ext_valid),
        .ext_req     (ext_req)
    );

    local_sram u_sram (
        .clk_rv    (clk_rv),
        .word_addr (ram_word_addr),
        .wdata     (mem_req.wdata),
        .wen       (ram_wen),
        .rdata     (ram_rdata)
    );

    // Character code in the low byte of the bus word
    text_vram u_vram (
        .clk_rv    (clk_rv),
        .wr_addr   (vram_word_addr),
        .wr_char   (mem_req.wdata[7:0]),
        .wen       (vram_wen),
        .disp_pos  (disp_pos),
        .disp_char (disp_char)
    );

    bus_response_mux u_resp (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .region        (region),
        .ctrl_wen      (ctrl_wen),
        .wdata         (mem_req.wdata),
        .delay_sel_det (delay_sel_det),
        .ram_rdata     (ram_rdata),
        .ext_rdata     (ext_rdata),
        .mem_rdata     (mem_rdata),
        .delay_sel     (delay_sel)
    );

endmodule

/* hw/text_vram.sv */
`timescale 1ns/10ps
`include "soc_bus_config.svh"

module text_vram (
    input  logic                        clk_rv,
    input  logic [`SOC_VRAM_AW-1:0]     wr_addr,
    input  logic [7:0]                  wr_char,
    input  logic                        wen,
    input  soc_bus_pkg::disp_pos_t      disp_pos,
    output logic [`SOC_CHAR_W-1:0]      disp_char
);

    localparam int VRAM_AW = `SOC_VRAM_AW;
    localparam int DEPTH   = 1 << VRAM_AW;
    // Row pitch in character cells
    localparam logic [VRAM_AW-1:0] COLS = VRAM_AW'(`SOC_TEXT_COLS);

    logic [7:0]         mem [DEPTH];
    logic [VRAM_AW-1:0] row_ext;
    logic [VRAM_AW-1:0] col_ext;
    logic [VRAM_AW-1:0] rd_addr;

    // ----------------------------------------------------------
    // CPU side
    // One character per bus word, low byte kept
    always_ff @(posedge clk_rv) begin
        if (wen) begin
            mem[wr_addr] <= wr_char;
        end
    end

    // ----------------------------------------------------------
    // Display side
    // Linear cell index is row * 80 + col
    assign row_ext = {{(VRAM_AW-`SOC_ROW_W){1'b0}}, disp_pos.row};
    assign col_ext = {{(VRAM_AW-`SOC_COL_W){1'b0}}, disp_pos.col};
    assign rd_addr = row_ext * COLS + col_ext;

    // One position per cycle, fully pipelined
    // Top bit of the byte not shown, glyph set is 7-bit
    always_ff @(posedge clk_rv) begin
        disp_char <= mem[rd_addr][`SOC_CHAR_W-1:0];
    end

    // Scan position must stay on screen, else it aliases the next row
    a_pos_on_screen: assert property (
        @(posedge clk_rv)
        !$isunknown(disp_pos) |->
            ((disp_pos.col < `SOC_TEXT_COLS) && (disp_pos.row < `SOC_TEXT_ROWS))
    );

endmodule

/* soc_bus.f */
+incdir+hw
hw/soc_bus_pkg.sv
hw/bus_request_decode.sv
hw/local_sram.sv
hw/text_vram.sv
hw/bus_response_mux.sv
hw/soc_bus_top.sv
verif/soc_bus_tb.sv

/* verif/soc_bus_tb.sv */
`timescale 1ns/10ps
`include "soc_bus_config.svh"

module soc_bus_tb;
    import soc_bus_pkg::*;

    localparam int NUM_STEPS     = 23;
    localparam int NUM_CELLS     = 5;
    localparam int READY_TIMEOUT = 50;
    // Stall code that asks the responder for a random stall
    localparam logic [7:0] STALL_RANDOM = 8'hFF;

    // One CPU access, zero wstrb is a read
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
        logic [`SOC_STRB_W-1:0] wstrb;
        logic [`SOC_DATA_W-1:0] wdata;
        logic [`SOC_DATA_W-1:0] exp;
        logic                   ext;
        logic [7:0]             stall;
    } step_t;

    // Screen cell and the byte written into it
    typedef struct packed {
        logic [`SOC_COL_W-1:0]  col;
        logic [`SOC_ROW_W-1:0]  row;
        logic [7:0]             chr;
    } cell_t;

    logic                       clk_rv;
    logic                       rst_rv;
    logic [`SOC_ADDR_W-1:0]     mem_la_addr;
    logic                       mem_valid;
    bus_req_t                   mem_req;
    logic                       mem_ready;
    logic [`SOC_DATA_W-1:0]     mem_rdata;
    logic                       ext_valid;
    ext_req_t                   ext_req;
    logic                       ext_ready;
    logic [`SOC_DATA_W-1:0]     ext_rdata;
    logic [`SOC_DELAY_W-1:0]    delay_sel_det;
    logic [`SOC_DELAY_W-1:0]    delay_sel;
    disp_pos_t                  disp_pos;
    logic [`SOC_CHAR_W-1:0]     disp_char;

    step_t                      steps [NUM_STEPS];
    cell_t                      cells [NUM_CELLS];
    // SDRAM model, aliased every 256 bytes
    logic [`SOC_DATA_W-1:0]     ext_mem [64];
    logic [7:0]                 ext_stall;
    logic                       ext_seen;
    logic [`SOC_EXT_ADDR_W-1:0] ext_addr_seen;
    int                         errors;
    int                         checks;
    bit                         timed_out;

    soc_bus_top DUT (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .mem_la_addr   (mem_la_addr),
        .mem_valid     (mem_valid),
        .mem_req       (mem_req),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .ext_valid     (ext_valid),
        .ext_req       (ext_req),
        .ext_ready     (ext_ready),
        .ext_rdata     (ext_rdata),
        .delay_sel_det (delay_sel_det),
        .delay_sel     (delay_sel),
        .disp_pos      (disp_pos),
        .disp_char     (disp_char)
    );

    always #5 clk_rv = ~clk_rv;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus table
    // Columns are addr, wstrb, wdata, expected read, external, stall
    task automatic fill_tables();
        steps[0]  = '{32'h0300_0000, 4'h0, 32'h0000_0000, 32'h0000_0013, 1'b0, 8'd0};
        // Byte lanes 0 and 2 overwritten
        steps[1]  = '{32'h0000_0100, 4'hF, 32'h1122_3344, 32'h0, 1'b0, 8'd0};
        steps[2]  = '{32'h0000_0100, 4'h5, 32'hAABB_CCDD, 32'h0, 1'b0, 8'd0};
        steps[3]  = '{32'h0000_0100, 4'h0, 32'h0000_0000, 32'h11BB_33DD, 1'b0, 8'd0};
        steps[4]  = '{32'h0000_0104, 4'hF, 32'h0000_0000, 32'h0, 1'b0, 8'd0};
        steps[5]  = '{32'h0000_0104, 4'h8, 32'h9988_7766, 32'h0, 1'b0, 8'd0};
        steps[6]  = '{32'h0000_0104, 4'h0, 32'h0000_0000, 32'h9900_0000, 1'b0, 8'd0};
        // Last RAM word
        steps[7]  = '{32'h0000_0FFC, 4'hF, 32'hCAFE_F00D, 32'h0, 1'b0, 8'd0};
        steps[8]  = '{32'h0000_0FFC, 4'h0, 32'h0000_0000, 32'hCAFE_F00D, 1'b0, 8'd0};
        // Delay select takes the low 5 bits
        steps[9]  = '{32'h0300_0000, 4'hF, 32'hABCD_EF0A, 32'h0, 1'b0, 8'd0};
        steps[10] = '{32'h0300_0000, 4'h0, 32'h0000_0000, 32'h0000_000A, 1'b0, 8'd0};
        // Cells (0,0) (5,2) (79,24) (10,7)
        steps[11] = '{32'h0800_0000, 4'h1, 32'h0000_0048, 32'h0, 1'b0, 8'd0};
        steps[12] = '{32'h0800_0294, 4'hF, 32'h0000_0069, 32'h0, 1'b0, 8'd0};
        steps[13] = '{32'h0800_1F3C, 4'hF, 32'h0000_00C1, 32'h0, 1'b0, 8'd0};
        steps[14] = '{32'h0800_08E8, 4'hF, 32'h1234_562A, 32'h0, 1'b0, 8'd0};
        steps[15] = '{32'h0800_0294, 4'h0, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0, 8'd0};
        // SDRAM window, fill pattern E000_0000 + index * 0001_0001
        steps[16] = '{32'h0C00_0010, 4'h0, 32'h0000_0000, 32'hE004_0004, 1'b1, 8'd0};
        steps[17] = '{32'h0C00_0020, 4'h3, 32'h1234_5678, 32'h0, 1'b1, 8'd3};
        steps[18] = '{32'h0C00_0020, 4'h0, 32'h0, 32'hE008_5678, 1'b1, STALL_RANDOM};
        steps[19] = '{32'h0DFF_FFFC, 4'h0, 32'h0, 32'hE03F_003F, 1'b1, STALL_RANDOM};
        steps[20] = '{32'h0C00_003C, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b1, STALL_RANDOM};
        steps[21] = '{32'h0C00_003C, 4'h0, 32'h0, 32'hDEAD_BEEF, 1'b1, 8'd5};
        // Hole in the map
        steps[22] = '{32'h0500_0000, 4'h0, 32'h0, 32'hFFFF_FFFF, 1'b0, 8'd0};
        // Display scan, same cell twice at the end
        cells[0]  = '{7'd0,  5'd0,  8'h48};
        cells[1]  = '{7'd5,  5'd2,  8'h69};
        cells[2]  = '{7'd79, 5'd24, 8'hC1};
        cells[3]  = '{7'd10, 5'd7,  8'h2A};
        cells[4]  = '{7'd0,  5'd0,  8'h48};
    endtask

    // ----------------------------------------------------------
    // CPU-side driver, one access per call
    task automatic run_step(input step_t s);
        logic [`SOC_DATA_W-1:0] rdata;
        int                     lat;
        bit                     got_ready;
        lat       = 0;
        got_ready = 1'b0;
        // Look-ahead address one cycle before mem_valid
        @(negedge clk_rv);
        mem_la_addr = s.addr;
        ext_stall   = s.stall;
        ext_seen    = 1'b0;
        @(negedge clk_rv);
        mem_valid     = 1'b1;
        mem_req.addr  = s.addr;
        mem_req.wdata = s.wdata;
        mem_req.wstrb = s.wstrb;
        while (!got_ready && (lat < READY_TIMEOUT)) begin
            @(negedge clk_rv);
            lat++;
            got_ready = (mem_ready === 1'b1);
        end
        rdata     = mem_rdata;
        mem_valid = 1'b0;
        mem_req   = '0;
        if (!got_ready) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR: mem_ready never arrived for the access to 0x%h", s.addr);
        end else begin
            if (s.wstrb == '0) begin
                compare_value("mem_rdata", rdata, s.exp);
            end
            if (s.ext) begin
                compare_value("ext_valid seen", ext_seen, 1);
                compare_value("ext_req.addr", ext_addr_seen, s.addr[`SOC_EXT_ADDR_W-1:0]);
            end else begin
                // Local target answers one cycle after mem_valid
                compare_value("mem_ready latency", lat, 1);
                compare_value("ext_valid seen", ext_seen, 0);
            end
        end
    endtask

    // Positions back to back, character due one cycle later
    task automatic scan_cells();
        for (int k = 0; k <= NUM_CELLS; k++) begin
            @(negedge clk_rv);
            if (k > 0) begin
                compare_value("disp_char", disp_char, cells[k-1].chr[`SOC_CHAR_W-1:0]);
            end
            if (k < NUM_CELLS) begin
                disp_pos.col = cells[k].col;
                disp_pos.row = cells[k].row;
            end
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // ----------------------------------------------------------
    // SDRAM responder
    // ext_valid sampled on the rising edge, ext_ready driven on the falling one
    initial begin : ext_responder
        int unsigned stall;
        int unsigned idx;
        void'($urandom(37));
        forever begin
            @(posedge clk_rv);
            if (ext_valid === 1'b1) begin
                ext_seen      = 1'b1;
                ext_addr_seen = ext_req.addr;
                idx           = ext_req.addr[7:2];
                if (ext_stall == STALL_RANDOM) begin
                    stall = $urandom % 6;
                end else begin
                    stall = ext_stall;
                end
                // Back-pressure, request must hold
                repeat (stall) begin
                    @(posedge clk_rv);
                    if (ext_valid !== 1'b1) begin
                        errors++;
                        $display("ERROR: ext_valid dropped before ext_ready was given");
                    end
                end
                @(negedge clk_rv);
                ext_ready = 1'b1;
                ext_rdata = ext_mem[idx];
                for (int b = 0; b < `SOC_STRB_W; b++) begin
                    if (ext_req.wstrb[b]) begin
                        ext_mem[idx][8*b +: 8] = ext_req.wdata[8*b +: 8];
                    end
                end
                @(negedge clk_rv);
                ext_ready = 1'b0;
            end
        end
    end

    initial begin : main
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        clk_rv        = 1'b0;
        rst_rv        = 1'b0;
        mem_la_addr   = '0;
        mem_valid     = 1'b0;
        mem_req       = '0;
        ext_ready     = 1'b0;
        ext_rdata     = '0;
        delay_sel_det = 5'h13;
        disp_pos      = '0;
        ext_stall     = '0;
        ext_seen      = 1'b0;
        ext_addr_seen = '0;
        for (int i = 0; i < 64; i++) begin
            ext_mem[i] = 32'hE000_0000 + i * 32'h0001_0001;
        end
        fill_tables();

        // Reset for 8 cycles
        repeat (8) @(negedge clk_rv);
        rst_rv = 1'b1;
        compare_value("delay_sel", delay_sel, delay_sel_det);
        compare_value("mem_ready", mem_ready, 0);
        compare_value("ext_valid", ext_valid, 0);

        for (int i = 0; (i < NUM_STEPS) && !timed_out; i++) begin
            run_step(steps[i]);
        end
        if (!timed_out) begin
            // Value from the control write row
            compare_value("delay_sel", delay_sel, steps[9].wdata[`SOC_DELAY_W-1:0]);
            scan_cells();
        end
        finish_run();
    end

endmodule
